//--- project.f
+incdir+include
design/rename_pkg.sv
design/ckpt_if.sv
design/map_table.sv
design/free_list.sv
design/branch_stack.sv
design/rename_unit.sv
testbench/tb_rename_unit.sv

//--- Makefile
# Verilator build and run of the rename stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_rename_unit
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
SIM       ?= V$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR SIM LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(SIM)
	-./$(OBJ_DIR)/$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_rename_unit.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module tb_rename_unit;

  localparam int          CLK_PERIOD = 100;
  localparam int          RST_CYCLES = 3;
  localparam int          WD_MARGIN  = 20;  // Slack cycles on top of the table.
  localparam logic [31:0] SEED       = 32'h0f73_470c;

  // CDB modes of a table row.
  localparam logic [1:0] CDB_NONE = 2'd0;
  localparam logic [1:0] CDB_WAKE = 2'd1;  // Opa set to the last dest and its tag broadcast.
  localparam logic [1:0] CDB_RAND = 2'd2;  // Broadcast any tag.

  // One table row repeated for reps cycles.
  typedef struct packed {
    logic [7:0]            reps;
    logic                  disp;      // Dispatch wanted. Dropped while stalled.
    logic                  branch;
    logic [1:0]            cdb;
    logic                  retire;    // Retire the oldest renamed instruction.
    logic                  zero_dst;  // Dest and opa forced to the zero register.
    rename_pkg::br_state_e st;
    logic                  stall;     // Expected stall_o in every cycle of the row.
  } stim_row_t;

  logic                  clk;
  logic                  rst;
  logic                  dispatch_en_i;
  logic                  is_branch_i;
  rename_pkg::areg_t     opa_areg_i;
  rename_pkg::areg_t     opb_areg_i;
  rename_pkg::areg_t     dest_areg_i;
  logic                  cdb_en_i;
  rename_pkg::preg_t     cdb_preg_i;
  logic                  retire_en_i;
  rename_pkg::preg_t     retire_preg_i;
  rename_pkg::br_state_e br_state_i;
  rename_pkg::preg_t     opa_preg_o;
  logic                  opa_rdy_o;
  rename_pkg::preg_t     opb_preg_o;
  logic                  opb_rdy_o;
  rename_pkg::preg_t     dest_new_preg_o;
  rename_pkg::preg_t     dest_old_preg_o;
  logic                  stall_o;

  // Reference model state.
  rename_pkg::map_image_t m_map;                 // {ready, preg} per areg.
  rename_pkg::preg_t      fl_mem [`PREG_NUM];    // Free names in allocation order.
  int                     fl_head;               // Pops so far.
  int                     fl_tail;               // Names ever made free.
  rename_pkg::map_image_t ck_map_q [$];          // Oldest checkpoint at index 0.
  int                     ck_head_q [$];
  int                     ck_disp_q [$];         // Dispatch count at the branch.
  rename_pkg::preg_t      old_dest [256];        // Old dest per dispatch kept for retire.
  int                     disp_cnt;
  int                     ret_idx;
  rename_pkg::areg_t      last_dest;
  rename_pkg::areg_t      woken_areg;            // Opa woken by the last broadcast.
  logic                   woken_v;

  stim_row_t tab [$];
  int        total_cycles;
  int        cur_row;
  int        fwd_seen;    // Operands made ready by same-cycle forwarding.
  int        reuse_seen;  // Dispatches that got a recycled preg.

  rename_unit dut0 (
    .clk             (clk),
    .rst             (rst),
    .dispatch_en_i   (dispatch_en_i),
    .is_branch_i     (is_branch_i),
    .opa_areg_i      (opa_areg_i),
    .opb_areg_i      (opb_areg_i),
    .dest_areg_i     (dest_areg_i),
    .cdb_en_i        (cdb_en_i),
    .cdb_preg_i      (cdb_preg_i),
    .retire_en_i     (retire_en_i),
    .retire_preg_i   (retire_preg_i),
    .br_state_i      (br_state_i),
    .opa_preg_o      (opa_preg_o),
    .opa_rdy_o       (opa_rdy_o),
    .opb_preg_o      (opb_preg_o),
    .opb_rdy_o       (opb_rdy_o),
    .dest_new_preg_o (dest_new_preg_o),
    .dest_old_preg_o (dest_old_preg_o),
    .stall_o         (stall_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s in row %0d: got 0x%0h, expected 0x%0h", name, cur_row, got, exp);
      $display("tests failed");
      $fatal(1, "Output mismatch");
    end
  endtask

  task automatic add_row(input int reps, input int disp, input int branch,
                         input logic [1:0] cdb, input int retire, input int zero_dst,
                         input rename_pkg::br_state_e st, input int stall);
    stim_row_t r;
    r.reps     = 8'(reps);
    r.disp     = (disp != 0);
    r.branch   = (branch != 0);
    r.cdb      = cdb;
    r.retire   = (retire != 0);
    r.zero_dst = (zero_dst != 0);
    r.st       = st;
    r.stall    = (stall != 0);
    tab.push_back(r);
  endtask

  // Free-list counts wrap on the buffer depth.
  function automatic rename_pkg::preg_t fl_slot(input int n);
    return rename_pkg::preg_t'(n[`PREG_W-1:0]);
  endfunction

  // Column order is reps, disp, branch, cdb, retire, zero_dst, br_state, stall.
  task automatic build_table();
    add_row(1,  1, 0, CDB_NONE, 0, 0, rename_pkg::BR_NONE,    0);  // Identity map.
    add_row(4,  1, 0, CDB_WAKE, 0, 0, rename_pkg::BR_NONE,    0);  // Forwarded wakeup.
    add_row(2,  1, 0, CDB_NONE, 0, 1, rename_pkg::BR_NONE,    0);  // Zero reg as dest.
    add_row(1,  1, 1, CDB_NONE, 0, 0, rename_pkg::BR_NONE,    0);  // Branch checkpoint.
    add_row(3,  1, 0, CDB_RAND, 0, 0, rename_pkg::BR_NONE,    0);  // Wrong path.
    add_row(1,  0, 0, CDB_NONE, 0, 0, rename_pkg::BR_WRONG,   0);  // Recover.
    add_row(1,  1, 1, CDB_NONE, 0, 0, rename_pkg::BR_NONE,    0);
    add_row(2,  1, 0, CDB_NONE, 0, 0, rename_pkg::BR_NONE,    0);
    add_row(1,  0, 0, CDB_NONE, 0, 0, rename_pkg::BR_CORRECT, 0);  // State kept.
    add_row(4,  1, 1, CDB_RAND, 0, 0, rename_pkg::BR_NONE,    0);  // Stack fills up.
    add_row(1,  1, 1, CDB_NONE, 0, 0, rename_pkg::BR_NONE,    1);  // Branch held.
    add_row(1,  1, 0, CDB_NONE, 0, 0, rename_pkg::BR_NONE,    0);  // Non-branch passes.
    add_row(1,  0, 0, CDB_NONE, 0, 0, rename_pkg::BR_CORRECT, 0);
    add_row(1,  1, 1, CDB_NONE, 0, 0, rename_pkg::BR_NONE,    0);
    add_row(1,  0, 0, CDB_NONE, 0, 0, rename_pkg::BR_WRONG,   0);  // 19 names free again.
    add_row(19, 1, 0, CDB_RAND, 0, 0, rename_pkg::BR_NONE,    0);  // Drain free list.
    add_row(2,  1, 0, CDB_NONE, 0, 0, rename_pkg::BR_NONE,    1);  // Empty.
    add_row(1,  0, 0, CDB_NONE, 1, 0, rename_pkg::BR_NONE,    1);
    add_row(8,  1, 0, CDB_WAKE, 1, 0, rename_pkg::BR_NONE,    0);  // Recycled names.
    add_row(1,  1, 1, CDB_NONE, 1, 0, rename_pkg::BR_NONE,    0);
    add_row(4,  1, 0, CDB_RAND, 1, 0, rename_pkg::BR_NONE,    0);
    add_row(1,  0, 0, CDB_NONE, 1, 0, rename_pkg::BR_WRONG,   0);  // Retire during recovery.
    add_row(6,  1, 0, CDB_WAKE, 0, 0, rename_pkg::BR_NONE,    0);
    add_row(1,  1, 0, CDB_NONE, 0, 0, rename_pkg::BR_NONE,    1);
    add_row(1,  0, 0, CDB_NONE, 1, 0, rename_pkg::BR_NONE,    1);
    add_row(1,  0, 0, CDB_NONE, 0, 0, rename_pkg::BR_NONE,    0);
  endtask

  task automatic reset_model();
    for (int i = 0; i < `AREG_NUM; i++) begin
      m_map[rename_pkg::areg_t'(i)] = {1'b1, rename_pkg::preg_t'(i)};  // Identity and ready.
    end
    for (int i = 0; i < `PREG_NUM; i++) begin
      fl_mem[i] = rename_pkg::preg_t'(`AREG_NUM + i);  // Upper half free after reset.
    end
    fl_head = 0;
    fl_tail = `PREG_NUM - `AREG_NUM;
    ck_map_q.delete();
    ck_head_q.delete();
    ck_disp_q.delete();
    disp_cnt   = 0;
    ret_idx    = 0;
    last_dest  = '0;
    woken_areg = '0;
    woken_v    = 1'b0;
  endtask

  task automatic run_cycle(input stim_row_t row);
    rename_pkg::areg_t      a;
    rename_pkg::areg_t      b;
    rename_pkg::areg_t      d;
    logic                   cdb_v;
    rename_pkg::preg_t      cdb_p;
    logic                   ret_v;
    rename_pkg::preg_t      ret_p;
    logic                   disp_v;
    logic                   a_rdy;
    logic                   b_rdy;
    int                     limit;
    rename_pkg::map_image_t nxt;

    @(posedge clk);
    a = rename_pkg::areg_t'($urandom % `AREG_NUM);
    b = rename_pkg::areg_t'($urandom % `AREG_NUM);
    d = rename_pkg::areg_t'($urandom % `AREG_NUM);
    if (row.zero_dst) begin
      a = rename_pkg::areg_t'(`ZERO_AREG);
      d = rename_pkg::areg_t'(`ZERO_AREG);
    end
    cdb_v = (row.cdb != CDB_NONE);
    cdb_p = rename_pkg::preg_t'($urandom % `PREG_NUM);
    if (row.cdb == CDB_WAKE) begin
      a     = last_dest;
      cdb_p = m_map[a][`PREG_W-1:0];  // Producer of the last dest finishes now.
      if (woken_v) begin
        b = woken_areg;  // Stored ready bit from last cycle's broadcast read back.
      end
    end
    woken_v    = (row.cdb == CDB_WAKE);
    woken_areg = a;
    // Only instructions older than the oldest open branch may retire.
    limit  = (ck_disp_q.size() > 0) ? ck_disp_q[0] : disp_cnt;
    ret_v  = row.retire && (ret_idx < limit);
    ret_p  = ret_v ? old_dest[ret_idx[7:0]] : '0;
    disp_v = row.disp && (fl_head != fl_tail) && (row.st != rename_pkg::BR_WRONG) &&
             !(row.branch && ck_head_q.size() == `BR_DEPTH);
    dispatch_en_i <= disp_v;
    is_branch_i   <= row.branch;
    opa_areg_i    <= a;
    opb_areg_i    <= b;
    dest_areg_i   <= d;
    cdb_en_i      <= cdb_v;
    cdb_preg_i    <= cdb_p;
    retire_en_i   <= ret_v;
    retire_preg_i <= ret_p;
    br_state_i    <= row.st;

    @(negedge clk);
    a_rdy = m_map[a][`PREG_W] | (cdb_v && m_map[a][`PREG_W-1:0] == cdb_p);
    b_rdy = m_map[b][`PREG_W] | (cdb_v && m_map[b][`PREG_W-1:0] == cdb_p);
    check_value("opa_preg_o", 32'(opa_preg_o), 32'(m_map[a][`PREG_W-1:0]));
    check_value("opa_rdy_o", 32'(opa_rdy_o), 32'(a_rdy));
    check_value("opb_preg_o", 32'(opb_preg_o), 32'(m_map[b][`PREG_W-1:0]));
    check_value("opb_rdy_o", 32'(opb_rdy_o), 32'(b_rdy));
    check_value("dest_old_preg_o", 32'(dest_old_preg_o), 32'(m_map[d][`PREG_W-1:0]));
    check_value("stall_o", 32'(stall_o), 32'(row.stall));
    if (a == rename_pkg::areg_t'(`ZERO_AREG)) begin
      check_value("opa_rdy_o", 32'(opa_rdy_o), 32'd1);  // Zero reg never waits.
    end
    if (!m_map[a][`PREG_W] && a_rdy) fwd_seen++;
    if (disp_v) begin
      check_value("dest_new_preg_o", 32'(dest_new_preg_o), 32'(fl_mem[fl_slot(fl_head)]));
      if (fl_head >= `PREG_NUM - `AREG_NUM) reuse_seen++;  // Past the reset pool.
    end

    // Advance the model across the coming edge.
    nxt = m_map;
    if (row.st == rename_pkg::BR_WRONG && ck_map_q.size() > 0) begin
      nxt      = ck_map_q[0];  // Oldest branch. Younger ones die with it.
      fl_head  = ck_head_q[0];
      disp_cnt = ck_disp_q[0];
      ck_map_q.delete();
      ck_head_q.delete();
      ck_disp_q.delete();
    end else begin
      if (cdb_v) begin
        for (int i = 0; i < `AREG_NUM; i++) begin
          if (m_map[rename_pkg::areg_t'(i)][`PREG_W-1:0] == cdb_p) begin
            nxt[rename_pkg::areg_t'(i)][`PREG_W] = 1'b1;
          end
        end
      end
      if (disp_v) begin
        old_dest[disp_cnt[7:0]] = m_map[d][`PREG_W-1:0];
        nxt[d]    = {1'b0, fl_mem[fl_slot(fl_head)]};  // Rename beats the broadcast.
        fl_head   = fl_head + 1;
        disp_cnt  = disp_cnt + 1;
        last_dest = d;
      end
      nxt[rename_pkg::areg_t'(`ZERO_AREG)][`PREG_W] = 1'b1;
      if (row.st == rename_pkg::BR_CORRECT && ck_map_q.size() > 0) begin
        void'(ck_map_q.pop_front());
        void'(ck_head_q.pop_front());
        void'(ck_disp_q.pop_front());
      end
      if (disp_v && row.branch) begin
        ck_map_q.push_back(nxt);  // State right after the branch renames.
        ck_head_q.push_back(fl_head);
        ck_disp_q.push_back(disp_cnt);
      end
    end
    if (ret_v) begin
      fl_mem[fl_slot(fl_tail)] = ret_p;
      fl_tail = fl_tail + 1;
      ret_idx = ret_idx + 1;
    end
    m_map = nxt;
  endtask

  // Watchdog sized from the table.
  initial begin
    #1;
    #((RST_CYCLES + total_cycles + WD_MARGIN) * CLK_PERIOD);
    $display("Timeout: the stimulus table did not finish in the expected time");
    $display("tests failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    void'($urandom(SEED));
    build_table();
    total_cycles = 0;
    foreach (tab[r]) total_cycles = total_cycles + int'(tab[r].reps);
    cur_row       = 0;
    fwd_seen      = 0;
    reuse_seen    = 0;
    rst           = 1'b1;
    dispatch_en_i = 1'b0;
    is_branch_i   = 1'b0;
    opa_areg_i    = '0;
    opb_areg_i    = '0;
    dest_areg_i   = '0;
    cdb_en_i      = 1'b0;
    cdb_preg_i    = '0;
    retire_en_i   = 1'b0;
    retire_preg_i = '0;
    br_state_i    = rename_pkg::BR_NONE;
    reset_model();
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < tab.size(); r++) begin
      cur_row = r;
      for (int k = 0; k < int'(tab[r].reps); k++) begin
        run_cycle(tab[r]);
      end
    end
    if (fwd_seen > 0 && reuse_seen > 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("Forwarding or preg reuse was never seen");
      $display("tests failed");
      $fatal(1, "Incomplete run");
    end
  end

endmodule

//--- design/rename_unit.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_unit (
  input  logic                   clk,
  input  logic                   rst,
  // Dispatch.
  input  logic                   dispatch_en_i,
  input  logic                   is_branch_i,
  input  rename_pkg::areg_t      opa_areg_i,
  input  rename_pkg::areg_t      opb_areg_i,
  input  rename_pkg::areg_t      dest_areg_i,
  // Completion broadcast.
  input  logic                   cdb_en_i,
  input  rename_pkg::preg_t      cdb_preg_i,
  // Retirement.
  input  logic                   retire_en_i,
  input  rename_pkg::preg_t      retire_preg_i,
  input  rename_pkg::br_state_e  br_state_i,
  // Renamed operands.
  output rename_pkg::preg_t      opa_preg_o,
  output logic                   opa_rdy_o,
  output rename_pkg::preg_t      opb_preg_o,
  output logic                   opb_rdy_o,
  // Renamed destination.
  output rename_pkg::preg_t      dest_new_preg_o,
  output rename_pkg::preg_t      dest_old_preg_o,
  output logic                   stall_o
);

  logic br_full;  // Checkpoint slots exhausted.

  // Snapshot and recovery paths.
  ckpt_if ckpt0 ();

  map_table map0 (
    .clk             (clk),
    .rst             (rst),
    .dispatch_en_i   (dispatch_en_i),
    .opa_areg_i      (opa_areg_i),
    .opb_areg_i      (opb_areg_i),
    .dest_areg_i     (dest_areg_i),
    .new_preg_i      (dest_new_preg_o),  // Free-list head goes straight into the map.
    .cdb_en_i        (cdb_en_i),
    .cdb_preg_i      (cdb_preg_i),
    .ckpt            (ckpt0.map_mp),
    .opa_preg_o      (opa_preg_o),
    .opb_preg_o      (opb_preg_o),
    .dest_old_preg_o (dest_old_preg_o),
    .opa_rdy_o       (opa_rdy_o),
    .opb_rdy_o       (opb_rdy_o)
  );

  free_list free0 (
    .clk           (clk),
    .rst           (rst),
    .dispatch_en_i (dispatch_en_i),
    .retire_en_i   (retire_en_i),
    .retire_preg_i (retire_preg_i),
    .br_full_i     (br_full),
    .is_branch_i   (is_branch_i),
    .ckpt          (ckpt0.free_mp),
    .new_preg_o    (dest_new_preg_o),
    .stall_o       (stall_o)
  );

  branch_stack br0 (
    .clk        (clk),
    .rst        (rst),
    .save_i     (dispatch_en_i & is_branch_i),  // Checkpoint only on branch dispatch.
    .br_state_i (br_state_i),
    .ckpt       (ckpt0.stack_mp),
    .full_o     (br_full)
  );

endmodule

//--- design/branch_stack.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module branch_stack (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   save_i,      // Branch dispatched this cycle.
  input  rename_pkg::br_state_e  br_state_i,  // Outcome of the oldest branch.
  ckpt_if.stack_mp               ckpt,
  output logic                   full_o       // All checkpoints in use.
);

  // Checkpoint storage. One slot per unresolved branch.
  rename_pkg::map_image_t img_mem  [`BR_DEPTH];  // Map snapshots.
  rename_pkg::fl_ptr_t    head_mem [`BR_DEPTH];  // Free-list heads.

  logic [`BR_PTR_W-1:0] rd_ptr_q;  // Oldest branch.
  logic [`BR_PTR_W-1:0] wr_ptr_q;  // Next free slot.
  logic [`BR_PTR_W:0]   count_q;   // Branches in flight.

  logic empty;
  logic push;
  logic pop;
  logic flush;

  assign empty  = (count_q == '0);
  assign full_o = (count_q == (`BR_PTR_W + 1)'(`BR_DEPTH));

  // Branches resolve in program order so only the oldest slot is ever read.
  assign flush = (br_state_i == rename_pkg::BR_WRONG) & ~empty;    // Mispredict.
  assign pop   = (br_state_i == rename_pkg::BR_CORRECT) & ~empty;  // Checkpoint no longer needed.
  assign push  = save_i & ~full_o & ~flush;

  // Recovery data.
  assign ckpt.restore  = flush;
  assign ckpt.rst_map  = img_mem[rd_ptr_q];
  assign ckpt.rst_head = head_mem[rd_ptr_q];

  // Control.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush) begin
      // Every younger branch is on the wrong path too.
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at BR_DEPTH.
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither.
      endcase
    end
  end

  // Capture the state right after the branch renames.
  always_ff @(posedge clk) begin
    if (push) begin
      img_mem[wr_ptr_q]  <= ckpt.snap_map;
      head_mem[wr_ptr_q] <= ckpt.snap_head;
    end
  end

endmodule

//--- design/free_list.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module free_list (
  input  logic               clk,
  input  logic               rst,
  input  logic               dispatch_en_i,  // Pop a name for the dest.
  input  logic               retire_en_i,    // Push a name back.
  input  rename_pkg::preg_t  retire_preg_i,  // Old dest of the retiring instruction.
  input  logic               br_full_i,      // No checkpoint slot left.
  input  logic               is_branch_i,    // Instruction at dispatch is a branch.
  ckpt_if.free_mp            ckpt,
  output rename_pkg::preg_t  new_preg_o,     // Name handed to the next dest.
  output logic               stall_o         // Hold dispatch.
);

  // Circular buffer of free names.
  rename_pkg::preg_t fifo_mem [`PREG_NUM];

  rename_pkg::fl_ptr_t head_q;  // Next name to hand out.
  rename_pkg::fl_ptr_t head_d;
  rename_pkg::fl_ptr_t tail_q;  // Next slot to fill on retire.

  logic empty;  // Nothing left to allocate.
  logic pop;

  // Pointers equal including the wrap bit.
  assign empty = (head_q == tail_q);

  assign pop = dispatch_en_i & ~empty;

  // Head entry is always presented.
  assign new_preg_o = fifo_mem[head_q[`PREG_W-1:0]];

  // Out of names or out of checkpoints for a branch.
  assign stall_o = empty | (br_full_i & is_branch_i);

  always_comb begin
    head_d = head_q;
    if (ckpt.restore) begin
      // Names taken on the wrong path go back in one step.
      head_d = ckpt.rst_head;
    end else if (pop) begin
      head_d = head_q + 1'b1;
    end
  end

  // Branch snapshot sees the head after the branch's own pop.
  assign ckpt.snap_head = head_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q <= '0;
      tail_q <= rename_pkg::fl_ptr_t'(`PREG_NUM - `AREG_NUM);  // Upper half is free.
    end else begin
      head_q <= head_d;
      if (retire_en_i) begin
        tail_q <= tail_q + 1'b1;  // Tail is untouched by recovery.
      end
    end
  end

  // Storage.
  always_ff @(posedge clk) begin
    if (rst) begin
      // Preload pregs AREG_NUM and up in ascending order.
      for (int i = 0; i < `PREG_NUM - `AREG_NUM; i++) begin
        fifo_mem[i] <= rename_pkg::preg_t'(`AREG_NUM + i);
      end
    end else if (retire_en_i) begin
      fifo_mem[tail_q[`PREG_W-1:0]] <= retire_preg_i;
    end
  end

endmodule

//--- design/map_table.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

module map_table (
  input  logic                clk,
  input  logic                rst,
  input  logic                dispatch_en_i,    // One instruction renamed this cycle.
  input  rename_pkg::areg_t   opa_areg_i,       // Source A.
  input  rename_pkg::areg_t   opb_areg_i,       // Source B.
  input  rename_pkg::areg_t   dest_areg_i,      // Destination.
  input  rename_pkg::preg_t   new_preg_i,       // Fresh name from the free list.
  input  logic                cdb_en_i,         // Result broadcast valid.
  input  rename_pkg::preg_t   cdb_preg_i,       // Tag of the finished result.
  ckpt_if.map_mp              ckpt,
  output rename_pkg::preg_t   opa_preg_o,
  output rename_pkg::preg_t   opb_preg_o,
  output rename_pkg::preg_t   dest_old_preg_o,  // Freed later when the instruction retires.
  output logic                opa_rdy_o,
  output logic                opb_rdy_o
);

  rename_pkg::map_image_t map_q;  // Live map.
  rename_pkg::map_image_t map_d;  // Next map.

  // Entries read at dispatch.
  rename_pkg::map_entry_t opa_ent;
  rename_pkg::map_entry_t opb_ent;
  rename_pkg::map_entry_t dest_ent;

  logic opa_cdb_hit;  // Producer of A broadcasts this cycle.
  logic opb_cdb_hit;  // Producer of B broadcasts this cycle.

  // Three read ports.
  assign opa_ent  = map_q[opa_areg_i];
  assign opb_ent  = map_q[opb_areg_i];
  assign dest_ent = map_q[dest_areg_i];

  assign opa_preg_o      = opa_ent[`PREG_W-1:0];
  assign opb_preg_o      = opb_ent[`PREG_W-1:0];
  assign dest_old_preg_o = dest_ent[`PREG_W-1:0];  // Previous mapping of the dest.

  // Same-cycle wakeup.
  // The stored ready bit only flips at the edge so the tag compare is forwarded here.
  assign opa_cdb_hit = cdb_en_i && (opa_ent[`PREG_W-1:0] == cdb_preg_i);
  assign opb_cdb_hit = cdb_en_i && (opb_ent[`PREG_W-1:0] == cdb_preg_i);

  assign opa_rdy_o = opa_ent[`PREG_W] | opa_cdb_hit;
  assign opb_rdy_o = opb_ent[`PREG_W] | opb_cdb_hit;

  // Next-state map.
  always_comb begin
    map_d = map_q;  // Hold by default.
    if (ckpt.restore) begin
      // Mispredict wins over everything else this cycle.
      map_d = ckpt.rst_map;
    end else begin
      // Associative search on the broadcast tag.
      if (cdb_en_i) begin
        for (int i = 0; i < `AREG_NUM; i++) begin
          if (map_q[i][`PREG_W-1:0] == cdb_preg_i) begin
            map_d[i][`PREG_W] = 1'b1;  // Producer done.
          end
        end
      end
      // Rename of the dest comes last.
      // A broadcast on the old name of the same dest is overwritten here.
      if (dispatch_en_i) begin
        map_d[dest_areg_i] = {1'b0, new_preg_i};  // New producer still in flight.
      end
    end
    map_d[`ZERO_AREG][`PREG_W] = 1'b1;  // Zero register never waits.
  end

  // Snapshot seen by the branch stack includes this cycle's rename.
  assign ckpt.snap_map = map_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity map, everything committed.
      for (int i = 0; i < `AREG_NUM; i++) begin
        map_q[i] <= {1'b1, rename_pkg::preg_t'(i)};
      end
    end else begin
      map_q <= map_d;
    end
  end

endmodule

//--- design/ckpt_if.sv
`timescale 1ns/1ps
`include "rename_consts.svh"

// Checkpoint traffic between the rename blocks.
interface ckpt_if;

  rename_pkg::map_image_t snap_map;   // Map after this cycle's updates.
  rename_pkg::fl_ptr_t    snap_head;  // Free-list head after this cycle's pop.
  rename_pkg::map_image_t rst_map;    // Map image to recover.
  rename_pkg::fl_ptr_t    rst_head;   // Free-list head to recover.
  logic                   restore;    // Single-cycle recovery strobe.

  // Map table side.
  modport map_mp (
    output snap_map,
    input  rst_map,
    input  restore
  );

  // Free list side. Only the head is ever rolled back.
  modport free_mp (
    output snap_head,
    input  rst_head,
    input  restore
  );

  // Branch stack captures snapshots and replays the oldest one.
  modport stack_mp (
    input  snap_map,
    input  snap_head,
    output rst_map,
    output rst_head,
    output restore
  );

endinterface

//--- design/rename_pkg.sv
`include "rename_consts.svh"

package rename_pkg;

  // Register indices.
  typedef logic [`AREG_W-1:0] areg_t;  // Architectural index.
  typedef logic [`PREG_W-1:0] preg_t;  // Physical register name.

  // One map entry. Ready sits in the top bit and the preg name below it.
  typedef logic [`PREG_W:0] map_entry_t;

  // Whole map indexed by architectural register.
  typedef map_entry_t [`AREG_NUM-1:0] map_image_t;

  // Free-list head or tail with wrap bit.
  typedef logic [`FL_PTR_W-1:0] fl_ptr_t;

  // Branch outcome reported by the ROB.
  typedef enum logic [1:0] {
    BR_NONE    = 2'd0,  // No branch resolves this cycle.
    BR_CORRECT = 2'd1,  // Oldest branch predicted right.
    BR_WRONG   = 2'd2   // Oldest branch mispredicted.
  } br_state_e;

endpackage

//--- include/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Architectural register file.
`define AREG_NUM 32
`define AREG_W 5

// Physical register file.
`define PREG_NUM 64
`define PREG_W 6

// Hardwired zero register. Never waits on a producer.
`define ZERO_AREG 31

// Branch checkpoints in flight.
`define BR_DEPTH 4
`define BR_PTR_W 2

// Free-list pointers carry one extra wrap bit.
`define FL_PTR_W (`PREG_W + 1)

`endif
